//--- source/periph_pkg.sv
// Package for the peripheral subsystem with bus widths and the address map
// Also holds register offsets and the APB request and response structs
package periph_pkg;

	// ==============================
	// Widths
	// ==============================

	localparam int W_PADDR = 16;
	localparam int W_DATA = 32;
	localparam int N_PADS = 11;
	localparam int W_PWM = 8;

	typedef logic [W_PADDR-1:0] addr_t;
	typedef logic [W_DATA-1:0] data_t;
	typedef logic [N_PADS-1:0] pads_t;
	typedef logic [W_PWM-1:0] pwm_val_t;

	// ==============================
	// Address map
	// ==============================

	// Each slave owns a 4 KiB window selected by the top address nibble
	localparam addr_t GPIO_BASE = 16'h0000;
	localparam addr_t PWM_BASE = 16'h1000;
	localparam addr_t SLAVE_MASK = 16'hf000;

	// GPIO register offsets within its window
	localparam addr_t GPIO_OUT = 16'h0000;
	localparam addr_t GPIO_OE = 16'h0004;
	localparam addr_t GPIO_IN = 16'h0008;

	// PWM register offsets, CTRL bit 0 is the enable
	localparam addr_t PWM_CTRL = 16'h0000;
	localparam addr_t PWM_DIV = 16'h0004;
	localparam addr_t PWM_LEVEL = 16'h0008;

	// ==============================
	// APB structs
	// ==============================

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		addr_t paddr;
		data_t pwdata;
	} apb_req_t;

	typedef struct packed {
		data_t prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// Slaves never stall, so they return no pready
	typedef struct packed {
		data_t prdata;
		logic pslverr;
	} slv_rsp_t;

endpackage

//--- source/apb_splitter.sv
// APB splitter for the GPIO and PWM windows
// Routes psel by address and merges the slave responses into one read path
module apb_splitter (
	input  periph_pkg::apb_req_t req,
	output periph_pkg::apb_rsp_t rsp,

	output periph_pkg::apb_req_t gpio_req,
	input  periph_pkg::slv_rsp_t gpio_rsp,

	output periph_pkg::apb_req_t pwm_req,
	input  periph_pkg::slv_rsp_t pwm_rsp
);

	periph_pkg::addr_t window;
	logic gpio_hit;
	logic pwm_hit;
	logic access;

	// ==============================
	// Address decode
	// ==============================

	assign window = req.paddr & periph_pkg::SLAVE_MASK;
	assign gpio_hit = window == periph_pkg::GPIO_BASE;
	assign pwm_hit = window == periph_pkg::PWM_BASE;

	// Second cycle of a transfer, where responses are sampled
	assign access = req.psel && req.penable;

	// Only psel is qualified per slave, the rest of the request fans out as is
	always_comb begin
		gpio_req = req;
		gpio_req.psel = req.psel && gpio_hit;

		pwm_req = req;
		pwm_req.psel = req.psel && pwm_hit;
	end

	// ==============================
	// Response merge
	// ==============================

	always_comb begin
		rsp.pready = 1'b1;
		if (gpio_hit) begin
			rsp.prdata = gpio_rsp.prdata;
			rsp.pslverr = gpio_rsp.pslverr;
		end else if (pwm_hit) begin
			rsp.prdata = pwm_rsp.prdata;
			rsp.pslverr = pwm_rsp.pslverr;
		end else begin
			// Nothing lives here, so flag a decode error during the access phase
			rsp.prdata = '0;
			rsp.pslverr = access;
		end
	end

endmodule

//--- source/gpio_regs.sv
// GPIO register block with output and output-enable registers
// Pad inputs pass through a two-flop synchronizer before they can be read
module gpio_regs (
	input  logic                 clk_sys,
	input  logic                 rst,

	input  periph_pkg::apb_req_t req,
	output periph_pkg::slv_rsp_t rsp,

	output periph_pkg::pads_t    padout,
	output periph_pkg::pads_t    padoe,
	input  periph_pkg::pads_t    padin
);

	periph_pkg::addr_t offs;
	periph_pkg::pads_t padin_meta;
	periph_pkg::pads_t padin_sync;
	logic wr_en;

	// Offset within the 4 KiB window
	assign offs = req.paddr & ~periph_pkg::SLAVE_MASK;

	assign wr_en = req.psel && req.penable && req.pwrite;

	// ==============================
	// Registers
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			padout <= '0;
			padoe <= '0;
		end else if (wr_en) begin
			case (offs)
			periph_pkg::GPIO_OUT: padout <= req.pwdata[periph_pkg::N_PADS-1:0];
			periph_pkg::GPIO_OE: padoe <= req.pwdata[periph_pkg::N_PADS-1:0];
			default: ;
			endcase
		end
	end

	// Pads are asynchronous to clk_sys
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			padin_meta <= '0;
			padin_sync <= '0;
		end else begin
			padin_meta <= padin;
			padin_sync <= padin_meta;
		end
	end

	// ==============================
	// Read path
	// ==============================

	always_comb begin
		case (offs)
		periph_pkg::GPIO_OUT: rsp.prdata = periph_pkg::data_t'(padout);
		periph_pkg::GPIO_OE: rsp.prdata = periph_pkg::data_t'(padoe);
		periph_pkg::GPIO_IN: rsp.prdata = periph_pkg::data_t'(padin_sync);
		default: rsp.prdata = '0;
		endcase
	end

	// GPIO_IN is read-only, a write there is refused and leaves everything as is
	assign rsp.pslverr = wr_en && (offs == periph_pkg::GPIO_IN);

endmodule

//--- source/pwm_tiny.sv
// Small PWM generator for an LCD backlight
// Prescaled 8-bit wrapping counter compared against a level register
module pwm_tiny (
	input  logic                 clk_sys,
	input  logic                 rst,

	input  periph_pkg::apb_req_t req,
	output periph_pkg::slv_rsp_t rsp,

	output logic                 pwm_out
);

	periph_pkg::addr_t offs;
	periph_pkg::pwm_val_t div_val;
	periph_pkg::pwm_val_t level_val;
	periph_pkg::pwm_val_t presc;
	periph_pkg::pwm_val_t ctr;
	logic en;
	logic en_next;
	logic wr_en;

	assign offs = req.paddr & ~periph_pkg::SLAVE_MASK;
	assign wr_en = req.psel && req.penable && req.pwrite;

	// Enable as it will be after this edge, so that a disabling write
	// silences the output straight away
	always_comb begin
		en_next = en;
		if (wr_en && offs == periph_pkg::PWM_CTRL)
			en_next = req.pwdata[0];
	end

	// ==============================
	// Registers
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			en <= 1'b0;
			div_val <= '0;
			level_val <= '0;
		end else begin
			en <= en_next;
			if (wr_en) begin
				case (offs)
				periph_pkg::PWM_DIV: div_val <= req.pwdata[periph_pkg::W_PWM-1:0];
				periph_pkg::PWM_LEVEL: level_val <= req.pwdata[periph_pkg::W_PWM-1:0];
				default: ;
				endcase
			end
		end
	end

	// ==============================
	// Counter and output
	// ==============================

	// Counter steps once every DIV+1 cycles, so each value lasts DIV+1 cycles
	always_ff @(posedge clk_sys) begin
		if (rst || !en_next) begin
			presc <= '0;
			ctr <= '0;
			pwm_out <= 1'b0;
		end else begin
			// >= copes with DIV being lowered below the running prescaler
			if (presc >= div_val) begin
				presc <= '0;
				ctr <= ctr + 1'b1;
			end else begin
				presc <= presc + 1'b1;
			end
			pwm_out <= ctr < level_val;
		end
	end

	always_comb begin
		case (offs)
		periph_pkg::PWM_CTRL: rsp.prdata = periph_pkg::data_t'(en);
		periph_pkg::PWM_DIV: rsp.prdata = periph_pkg::data_t'(div_val);
		periph_pkg::PWM_LEVEL: rsp.prdata = periph_pkg::data_t'(level_val);
		default: rsp.prdata = '0;
		endcase
	end

	// Every offset in the window is accepted
	assign rsp.pslverr = 1'b0;

endmodule

//--- source/periph_subsys.sv
// Peripheral subsystem top level
// APB splitter feeding the GPIO block and the PWM generator
module periph_subsys (
	input  logic                 clk_sys,
	input  logic                 rst,

	input  periph_pkg::apb_req_t apb_req,
	output periph_pkg::apb_rsp_t apb_rsp,

	output periph_pkg::pads_t    padout,
	output periph_pkg::pads_t    padoe,
	input  periph_pkg::pads_t    padin,

	output logic                 pwm_out
);

	// ==============================
	// Interconnect
	// ==============================

	periph_pkg::apb_req_t gpio_req;
	periph_pkg::slv_rsp_t gpio_rsp;
	periph_pkg::apb_req_t pwm_req;
	periph_pkg::slv_rsp_t pwm_rsp;

	apb_splitter apb_splitter_inst (
		.req      (apb_req),
		.rsp      (apb_rsp),
		.gpio_req (gpio_req),
		.gpio_rsp (gpio_rsp),
		.pwm_req  (pwm_req),
		.pwm_rsp  (pwm_rsp)
	);

	// ==============================
	// Slaves
	// ==============================

	gpio_regs gpio_regs_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.req     (gpio_req),
		.rsp     (gpio_rsp),
		.padout  (padout),
		.padoe   (padoe),
		.padin   (padin)
	);

	// Backlight PWM
	pwm_tiny pwm_tiny_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.req     (pwm_req),
		.rsp     (pwm_rsp),
		.pwm_out (pwm_out)
	);

endmodule

//--- sim/periph_asserts.sv
// APB and reset assertions for the subsystem top level, bound into the DUT
module periph_asserts (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  periph_pkg::apb_req_t apb_req,
	input  periph_pkg::apb_rsp_t apb_rsp,
	input  periph_pkg::pads_t    padoe
);

	// Slaves never stall
	assert property (@(posedge clk_sys) disable iff (rst)
		(apb_req.psel && apb_req.penable) |-> apb_rsp.pready)
		else $error("pready low in an access phase");

	assert property (@(posedge clk_sys) disable iff (rst)
		!(apb_req.psel && apb_req.penable) |-> !apb_rsp.pslverr)
		else $error("pslverr high outside an access phase");

	assert property (@(posedge clk_sys) $fell(rst) |-> padoe == '0)
		else $error("padoe not cleared by reset");

endmodule

bind periph_subsys periph_asserts periph_asserts_inst (.*);

//--- sim/periph_checker.sv
// Checker for the peripheral subsystem
// Register model, bus and pad comparisons, per-test lines
module periph_checker (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  periph_pkg::apb_req_t apb_req,
	input  periph_pkg::apb_rsp_t apb_rsp,
	input  periph_pkg::pads_t    padout,
	input  periph_pkg::pads_t    padoe,
	input  periph_pkg::pads_t    padin,
	input  logic                 pwm_out,
	input  int                   test_id,
	input  logic                 test_end,
	input  logic                 pwm_window,
	output int                   errors,
	output int                   checks
);

	periph_pkg::pads_t m_out;
	periph_pkg::pads_t m_oe;
	logic m_en;
	periph_pkg::pwm_val_t m_div;
	periph_pkg::pwm_val_t m_level;
	periph_pkg::pads_t last_padin;
	int stable;
	int test_errors;
	int high_count;
	logic window_d;
	logic [33:0] exp;

	// Returns {compare data, pslverr, prdata} for an access at addr
	function automatic logic [33:0] expect_rsp(input periph_pkg::addr_t addr, input logic write);
		periph_pkg::addr_t win;
		periph_pkg::addr_t offs;
		logic chk;
		logic err;
		periph_pkg::data_t d;
		win = addr & periph_pkg::SLAVE_MASK;
		offs = addr & ~periph_pkg::SLAVE_MASK;
		chk = 1'b1;
		err = 1'b0;
		d = '0;
		if (win == periph_pkg::GPIO_BASE) begin
			if (offs == periph_pkg::GPIO_OUT)
				d = periph_pkg::data_t'(m_out);
			else if (offs == periph_pkg::GPIO_OE)
				d = periph_pkg::data_t'(m_oe);
			else if (offs == periph_pkg::GPIO_IN) begin
				d = periph_pkg::data_t'(last_padin);
				chk = stable >= 3;
				err = write;
			end
		end else if (win == periph_pkg::PWM_BASE) begin
			if (offs == periph_pkg::PWM_CTRL)
				d = periph_pkg::data_t'(m_en);
			else if (offs == periph_pkg::PWM_DIV)
				d = periph_pkg::data_t'(m_div);
			else if (offs == periph_pkg::PWM_LEVEL)
				d = periph_pkg::data_t'(m_level);
		end else begin
			err = 1'b1;
		end
		if (write)
			chk = 1'b0;
		return {chk, err, d};
	endfunction

	task automatic apply_write(input periph_pkg::addr_t addr, input periph_pkg::data_t data);
		case (addr)
		periph_pkg::GPIO_BASE | periph_pkg::GPIO_OUT: m_out = data[periph_pkg::N_PADS-1:0];
		periph_pkg::GPIO_BASE | periph_pkg::GPIO_OE: m_oe = data[periph_pkg::N_PADS-1:0];
		periph_pkg::PWM_BASE | periph_pkg::PWM_CTRL: m_en = data[0];
		periph_pkg::PWM_BASE | periph_pkg::PWM_DIV: m_div = data[periph_pkg::W_PWM-1:0];
		periph_pkg::PWM_BASE | periph_pkg::PWM_LEVEL: m_level = data[periph_pkg::W_PWM-1:0];
		default: ;
		endcase
	endtask

	task automatic compare_value(input string name, input logic [31:0] expv,
			input logic [31:0] act);
		checks++;
		if (expv !== act) begin
			$display("mismatch at %0t: %s expected %h, got %h", $time, name, expv, act);
			errors++;
			test_errors++;
		end
	endtask

	// ==============================
	// Comparison at the falling edge
	// ==============================

	// Outputs are settled half a cycle away from the edges the DUT uses
	always @(negedge clk_sys) begin
		if (rst) begin
			m_out = '0;
			m_oe = '0;
			m_en = 1'b0;
			m_div = '0;
			m_level = '0;
			last_padin = padin;
			stable = 0;
			test_errors = 0;
			high_count = 0;
			window_d = 1'b0;
			errors = 0;
			checks = 0;
		end else begin
			compare_value("padout", 32'(m_out), 32'(padout));
			compare_value("padoe", 32'(m_oe), 32'(padoe));
			if (!m_en)
				compare_value("pwm_out", 32'h0, 32'(pwm_out));
			if (pwm_window)
				high_count += int'(pwm_out);
			if (window_d && !pwm_window) begin
				compare_value("pwm_out high cycles", 32'(int'(m_level) * (int'(m_div) + 1)),
					32'(high_count));
				high_count = 0;
			end
			window_d = pwm_window;
			if (apb_req.psel && apb_req.penable && apb_rsp.pready) begin
				exp = expect_rsp(apb_req.paddr, apb_req.pwrite);
				compare_value("pslverr", 32'(exp[32]), 32'(apb_rsp.pslverr));
				if (exp[33])
					compare_value("prdata", exp[31:0], apb_rsp.prdata);
				if (apb_req.pwrite && !exp[32])
					apply_write(apb_req.paddr, apb_req.pwdata);
			end
			if (padin == last_padin)
				stable++;
			else
				stable = 0;
			last_padin = padin;
			if (test_end) begin
				$display("test %0d finished with %0d errors", test_id, test_errors);
				test_errors = 0;
			end
		end
	end

endmodule

//--- sim/periph_tb.sv
// Testbench top for the peripheral subsystem
// Clock, reset, APB stimulus tasks, the DUT and the checker
module periph_tb;

	// PWM window of 256*3 cycles plus about 100 transfers of 3 cycles, with a wide margin
	localparam int CYCLE_LIMIT = 4000;
	localparam int PWM_WINDOW = 256 * 3;

	logic clk_sys;
	logic rst;
	periph_pkg::apb_req_t apb_req;
	periph_pkg::apb_rsp_t apb_rsp;
	periph_pkg::pads_t padout;
	periph_pkg::pads_t padoe;
	periph_pkg::pads_t padin;
	logic pwm_out;
	int test_id;
	logic test_end;
	logic pwm_window;
	int errors;
	int checks;
	int cycles;
	int seed;
	periph_pkg::addr_t reg_list [6];

	periph_subsys periph_subsys_inst (
		.clk_sys (clk_sys),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.padout  (padout),
		.padoe   (padoe),
		.padin   (padin),
		.pwm_out (pwm_out)
	);

	periph_checker periph_checker_inst (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.apb_req    (apb_req),
		.apb_rsp    (apb_rsp),
		.padout     (padout),
		.padoe      (padoe),
		.padin      (padin),
		.pwm_out    (pwm_out),
		.test_id    (test_id),
		.test_end   (test_end),
		.pwm_window (pwm_window),
		.errors     (errors),
		.checks     (checks)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	// ==============================
	// Stimulus tasks
	// ==============================

	// Setup phase, access phase, then wait for pready at the completing edge
	task automatic apb_xfer(input logic write, input periph_pkg::addr_t addr,
			input periph_pkg::data_t data);
		@(posedge clk_sys);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= write;
		apb_req.paddr <= addr;
		apb_req.pwdata <= data;
		@(posedge clk_sys);
		apb_req.penable <= 1'b1;
		do
			@(posedge clk_sys);
		while (!apb_rsp.pready);
		apb_req.psel <= 1'b0;
		apb_req.penable <= 1'b0;
	endtask

	task automatic apb_write(input periph_pkg::addr_t addr, input periph_pkg::data_t data);
		apb_xfer(1'b1, addr, data);
	endtask

	task automatic apb_read(input periph_pkg::addr_t addr);
		apb_xfer(1'b0, addr, '0);
	endtask

	task automatic read_all_regs();
		foreach (reg_list[i])
			apb_read(reg_list[i]);
	endtask

	task automatic finish_test();
		@(posedge clk_sys);
		test_end <= 1'b1;
		@(posedge clk_sys);
		test_end <= 1'b0;
		test_id <= test_id + 1;
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		clk_sys = 1'b0;
		rst = 1'b1;
		apb_req = '0;
		padin = '0;
		test_id = 1;
		test_end = 1'b0;
		pwm_window = 1'b0;
		cycles = 0;
		seed = 32'h79e018fc;
		reg_list[0] = periph_pkg::GPIO_BASE | periph_pkg::GPIO_OUT;
		reg_list[1] = periph_pkg::GPIO_BASE | periph_pkg::GPIO_OE;
		reg_list[2] = periph_pkg::GPIO_BASE | periph_pkg::GPIO_IN;
		reg_list[3] = periph_pkg::PWM_BASE | periph_pkg::PWM_CTRL;
		reg_list[4] = periph_pkg::PWM_BASE | periph_pkg::PWM_DIV;
		reg_list[5] = periph_pkg::PWM_BASE | periph_pkg::PWM_LEVEL;
		repeat (5) @(posedge clk_sys);
		rst <= 1'b0;

		// Reset values
		read_all_regs();
		finish_test();

		// GPIO readback, then random traffic on both slaves
		apb_write(reg_list[0], 32'hffff_fa5a);
		apb_write(reg_list[1], 32'h0000_0c3f);
		apb_read(reg_list[0]);
		apb_read(reg_list[1]);
		repeat (40) begin
			apb_xfer($random(seed) & 1, reg_list[$unsigned($random(seed)) % 6], $random(seed));
		end
		finish_test();

		// Synchronized pad input and the read-only GPIO_IN
		@(posedge clk_sys);
		padin <= $random(seed);
		repeat (6) @(posedge clk_sys);
		apb_read(reg_list[2]);
		apb_write(reg_list[2], 32'h0000_0123);
		apb_read(reg_list[2]);
		finish_test();

		// Unmapped windows
		apb_write(16'h2000, 32'h0000_0155);
		apb_write(16'hf004, 32'h0000_0777);
		apb_read(16'h2000);
		apb_read(16'hf004);
		read_all_regs();
		finish_test();

		// Duty cycle over one full PWM period
		apb_write(reg_list[3], 32'h0);
		apb_write(reg_list[4], 32'd2);
		apb_write(reg_list[5], 32'd64);
		apb_write(reg_list[3], 32'h1);
		repeat (4) @(posedge clk_sys);
		pwm_window <= 1'b1;
		repeat (PWM_WINDOW) @(posedge clk_sys);
		pwm_window <= 1'b0;
		repeat (2) @(posedge clk_sys);
		finish_test();

		// Disable keeps DIV and LEVEL
		apb_write(reg_list[3], 32'h0);
		repeat (20) @(posedge clk_sys);
		read_all_regs();
		finish_test();

		repeat (2) @(posedge clk_sys);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- filelist.f
source/periph_pkg.sv
source/apb_splitter.sv
source/gpio_regs.sv
source/pwm_tiny.sv
source/periph_subsys.sv
sim/periph_asserts.sv
sim/periph_checker.sv
sim/periph_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module periph_tb -o periph_sim

./obj_dir/periph_sim > sim.log
cat sim.log

if grep -q "All checks passed" sim.log; then
	exit 0
else
	exit 1
fi
